// File: Bender.yml
package:
  name: fprint_store_unit

sources:
  - files:
      - source/fprint_pkg.sv
      - source/bus_pkg.sv
      - source/sync_fifo.sv
      - source/store_decode.sv
      - source/crc_accumulator.sv
      - source/store_buffer.sv
      - source/fprint_store_unit.sv
  - target: test
    files:
      - test/bus_responder.sv
      - test/fprint_store_tb.sv

// File: files.f
source/fprint_pkg.sv
source/bus_pkg.sv
source/sync_fifo.sv
source/store_decode.sv
source/crc_accumulator.sv
source/store_buffer.sv
source/fprint_store_unit.sv
test/bus_responder.sv
test/fprint_store_tb.sv

// File: source/bus_pkg.sv
// Bus side widths and the entry carried through the store pipeline
package bus_pkg;

	// Word address on the memory-mapped bus
	typedef logic [26:0] bus_addr_t;

	// One bus data word
	typedef logic [31:0] bus_data_t;

	// One store in flight, 64 bits
	typedef struct packed {
		bus_addr_t             address;   // Word address
		bus_data_t             data;      // Store data, or the CRC for a fingerprint
		fprint_pkg::task_key_t key;       // Task that issued the store
		logic                  is_fprint; // Address hit the comparator CRC slot
	} store_entry_t;

endpackage

// File: source/crc_accumulator.sv
`timescale 1ns/1ps

// CRC stage, folds ordinary data into a CRC-32 and fills in fingerprint entries
module crc_accumulator (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  dec_valid,
	input  bus_pkg::store_entry_t dec_entry,
	input  logic                  crc_ready_in,
	output logic                  dec_ready,
	output logic                  crc_valid,
	output bus_pkg::store_entry_t crc_entry,
	output logic                  fprint_done
);
	fprint_pkg::crc_t crc; // Running CRC of the current block
	logic take;

	// One data word, LSB first, no final inversion
	function automatic fprint_pkg::crc_t crc_fold(input fprint_pkg::crc_t seed,
			input bus_pkg::bus_data_t word);
		fprint_pkg::crc_t c;
		c = seed;
		for (int i = 0; i < $bits(word); i++) begin
			if (c[0] ^ word[i])
				c = (c >> 1) ^ fprint_pkg::CRC_POLY;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	assign dec_ready   = ~crc_valid | crc_ready_in; // Same rule as decode
	assign take        = dec_valid & dec_ready;
	assign fprint_done = take & dec_entry.is_fprint; // Pulses on the capture cycle

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			crc_valid <= 1'b0;
			crc       <= fprint_pkg::CRC_INIT;
		end else begin
			if (take)
				crc_valid <= 1'b1;
			else if (crc_ready_in)
				crc_valid <= 1'b0;

			// CRC moves only on the accepting edge
			if (take) begin
				if (dec_entry.is_fprint)
					crc <= fprint_pkg::CRC_INIT; // New block starts
				else
					crc <= crc_fold(crc, dec_entry.data);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			crc_entry <= dec_entry;
			if (dec_entry.is_fprint)
				crc_entry.data <= crc; // Fingerprint carries the block CRC
		end
	end

endmodule

// File: source/fprint_pkg.sv
// CRC and fingerprint definitions shared by the CRC stage and the store buffer
package fprint_pkg;

	// Running CRC-32 value
	typedef logic [31:0] crc_t;

	// Task identifier attached to every store
	typedef logic [3:0] task_key_t;

	// Low word address bits compared against the comparator CRC slot
	typedef logic [5:0] crc_offset_t;

	// Beat tag placed between CRC half and key
	typedef logic [11:0] fprint_tag_t;

	// Reflected CRC-32 polynomial, shifted in LSB first
	localparam crc_t CRC_POLY = 32'hEDB88320;
	localparam crc_t CRC_INIT = 32'hFFFFFFFF; // Seed after reset and after each fingerprint

	// Comparator CRC register, word offset inside the comparator window
	localparam crc_offset_t COMPARATOR_CRC_OFFSET = 6'h10;

	// Tags telling the comparator which half of the CRC a beat carries
	localparam fprint_tag_t FPRINT_TAG_LOW  = 12'h000;
	localparam fprint_tag_t FPRINT_TAG_HIGH = 12'h002;

endpackage

// File: source/fprint_store_unit.sv
`timescale 1ns/1ps

// Fingerprinting store unit, decode then CRC then store buffer
module fprint_store_unit #(
	parameter int FIFO_DEPTH_LOG2 = 3
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  store_valid,
	output logic                  store_ready,
	input  bus_pkg::bus_addr_t    store_address,
	input  bus_pkg::bus_data_t    store_data,
	input  fprint_pkg::task_key_t store_key,
	input  logic                  pause,         // One-cycle pulse
	input  logic                  fprint_enable, // Level
	output bus_pkg::bus_addr_t    master_address,
	output logic                  master_write,
	output bus_pkg::bus_data_t    master_writedata,
	input  logic                  master_waitrequest
);
	logic dec_valid;
	logic dec_ready;
	bus_pkg::store_entry_t dec_entry;
	logic crc_valid;
	logic crc_ready;
	bus_pkg::store_entry_t crc_entry;
	logic fprint_done;

	store_decode store_decode_i (
		.clk(clk),
		.reset(reset),
		.store_valid(store_valid),
		.store_address(store_address),
		.store_data(store_data),
		.store_key(store_key),
		.dec_ready(dec_ready),
		.store_ready(store_ready),
		.dec_valid(dec_valid),
		.dec_entry(dec_entry)
	);

	crc_accumulator crc_accumulator_i (
		.clk(clk),
		.reset(reset),
		.dec_valid(dec_valid),
		.dec_entry(dec_entry),
		.crc_ready_in(crc_ready),
		.dec_ready(dec_ready),
		.crc_valid(crc_valid),
		.crc_entry(crc_entry),
		.fprint_done(fprint_done)
	);

	store_buffer #(
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
	) store_buffer_i (
		.clk(clk),
		.reset(reset),
		.crc_valid(crc_valid),
		.crc_entry(crc_entry),
		.fprint_done(fprint_done),
		.pause(pause),
		.fprint_enable(fprint_enable),
		.master_waitrequest(master_waitrequest),
		.crc_ready(crc_ready),
		.master_address(master_address),
		.master_write(master_write),
		.master_writedata(master_writedata)
	);

endmodule

// File: source/store_buffer.sv
`timescale 1ns/1ps

// Result stage, buffers entries and issues them as bus writes
module store_buffer #(
	parameter int FIFO_DEPTH_LOG2 = 3
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  crc_valid,
	input  bus_pkg::store_entry_t crc_entry,
	input  logic                  fprint_done,
	input  logic                  pause,
	input  logic                  fprint_enable,
	input  logic                  master_waitrequest,
	output logic                  crc_ready,
	output bus_pkg::bus_addr_t    master_address,
	output logic                  master_write,
	output bus_pkg::bus_data_t    master_writedata
);
	typedef enum logic [2:0] {
		idle,
		load,
		check,
		write,
		fprint_low,
		fprint_gap,
		fprint_high
	} sb_state_t;

	sb_state_t state;
	bus_pkg::store_entry_t fifo_out;
	bus_pkg::store_entry_t cur;  // Entry being issued
	logic fifo_empty;
	logic fifo_full;
	logic accept;      // Entry taken from the CRC stage
	logic crc_pending; // Fingerprint produced, not yet resolved
	logic legal;       // A later store has arrived since then
	logic drop_req;    // Pause seen before the fingerprint reached check
	logic drop;
	logic fprint_end;  // High beat of a fingerprint completes

	assign crc_ready  = ~fifo_full;
	assign accept     = crc_valid & crc_ready;
	assign drop       = pause | drop_req;
	assign fprint_end = (state == fprint_high) & ~master_waitrequest;

	sync_fifo #(
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
	) entry_fifo (
		.clk(clk),
		.reset(reset),
		.wr_en(accept),
		.data_in(crc_entry),
		.rd_en(state == load), // Pop while the head is latched
		.data_out(fifo_out),
		.empty(fifo_empty),
		.full(fifo_full)
	);

	// Legality of the outstanding fingerprint.
	// Only the fingerprint's own completion clears it, so older ordinary writes
	// draining ahead of it do not throw away the evidence of a later store.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			crc_pending <= 1'b0;
			legal       <= 1'b0;
			drop_req    <= 1'b0;
		end else begin
			if (fprint_done)
				crc_pending <= 1'b1;
			else if (fprint_end | pause)
				crc_pending <= 1'b0;

			// The fingerprint entry itself does not count as a later store
			if (crc_pending & accept & ~crc_entry.is_fprint)
				legal <= 1'b1;
			else if (fprint_end | pause)
				legal <= 1'b0;

			if (state == check && cur.is_fprint && drop)
				drop_req <= 1'b0; // Consumed
			else if (pause & (crc_pending | fprint_done))
				drop_req <= 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle:       if (!fifo_empty) state <= load;
				load:       state <= check;
				check: begin
					if (!cur.is_fprint)
						state <= write;
					else if (drop)
						state <= idle; // Fingerprint discarded
					else if (!fprint_enable || legal)
						state <= fprint_low;
				end
				write:       if (!master_waitrequest) state <= idle;
				fprint_low:  if (!master_waitrequest) state <= fprint_gap;
				fprint_gap:  state <= fprint_high; // One quiet cycle between beats
				fprint_high: if (!master_waitrequest) state <= idle;
				default:     state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == load)
			cur <= fifo_out;
	end

	assign master_write   = (state == write) | (state == fprint_low) | (state == fprint_high);
	assign master_address = cur.address;

	always_comb begin
		case (state)
			fprint_low:  master_writedata = {cur.data[15:0], fprint_pkg::FPRINT_TAG_LOW, cur.key};
			fprint_high: master_writedata = {cur.data[31:16], fprint_pkg::FPRINT_TAG_HIGH, cur.key};
			default:     master_writedata = cur.data; // Ordinary store
		endcase
	end

endmodule

// File: source/store_decode.sv
`timescale 1ns/1ps

// Decode stage, registers processor stores and classifies the address
module store_decode (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  store_valid,
	input  bus_pkg::bus_addr_t    store_address,
	input  bus_pkg::bus_data_t    store_data,
	input  fprint_pkg::task_key_t store_key,
	input  logic                  dec_ready,
	output logic                  store_ready,
	output logic                  dec_valid,
	output bus_pkg::store_entry_t dec_entry
);
	logic take; // Store accepted this cycle

	// Free slot, or the held entry leaves on this edge
	assign store_ready = ~dec_valid | dec_ready;
	assign take        = store_valid & store_ready;

	// Valid bit
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else if (take) begin
			dec_valid <= 1'b1;
		end else if (dec_ready) begin
			dec_valid <= 1'b0; // Drained, nothing new
		end
	end

	// Payload, loaded only on acceptance
	always_ff @(posedge clk) begin
		if (take) begin
			dec_entry.address <= store_address;
			dec_entry.data    <= store_data;
			dec_entry.key     <= store_key;
			// Only place the comparator CRC slot is recognised
			dec_entry.is_fprint <= (store_address[5:0] == fprint_pkg::COMPARATOR_CRC_OFFSET);
		end
	end

endmodule

// File: source/sync_fifo.sv
`timescale 1ns/1ps

// Circular buffer of store entries, show-ahead output
module sync_fifo #(
	parameter int FIFO_DEPTH_LOG2 = 3
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wr_en,
	input  bus_pkg::store_entry_t data_in,
	input  logic                  rd_en,
	output bus_pkg::store_entry_t data_out,
	output logic                  empty,
	output logic                  full
);
	localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

	bus_pkg::store_entry_t mem [DEPTH];
	logic [FIFO_DEPTH_LOG2-1:0] wr_ptr; // Wraps on its own
	logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
	logic [FIFO_DEPTH_LOG2:0]   count;  // One bit wider to hold DEPTH
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en & ~full;  // Writes into a full buffer are ignored
	assign do_rd = rd_en & ~empty;

	assign empty    = (count == '0);
	assign full     = (count == DEPTH[FIFO_DEPTH_LOG2:0]);
	assign data_out = mem[rd_ptr]; // Head always visible

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= data_in;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			// Count only moves when exactly one side acts
			if (do_wr & ~do_rd)
				count <= count + 1'b1;
			else if (do_rd & ~do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

// File: test/bus_responder.sv
`timescale 1ns/1ps

// Bus slave model with random wait requests and a log of completed writes
module bus_responder (
	input  logic               clk,
	input  logic               reset,
	input  logic               stall,              // Holds wait request high
	input  bus_pkg::bus_addr_t master_address,
	input  logic               master_write,
	input  bus_pkg::bus_data_t master_writedata,
	output logic               master_waitrequest
);
	bus_pkg::bus_addr_t addr_log [$]; // Completed writes, in bus order
	logic rand_wait = 1'b0;

	assign master_waitrequest = stall | rand_wait;

	// Only random stream of the run
	initial begin
		void'($urandom(32'hcbd6));
		forever begin
			@(negedge clk);
			rand_wait = ($urandom_range(3) == 0); // About one cycle in four
		end
	end

	always @(posedge clk) begin
		if (!reset && master_write && !master_waitrequest) begin
			addr_log.push_back(master_address);
		end
	end

endmodule

// File: test/fprint_store_tb.sv
`timescale 1ns/1ps

// Testbench for the fingerprinting store unit
module fprint_store_tb;
	localparam int CLK_PERIOD = 40;
	localparam int NUM_STORES = 12 + 6 + 7 + 4 + 16; // All five tests

	typedef struct packed {
		bus_pkg::bus_addr_t address;
		bus_pkg::bus_data_t data;
	} bus_write_t;

	logic clk = 1'b0;
	logic reset;
	logic store_valid;
	logic store_ready;
	bus_pkg::bus_addr_t store_address;
	bus_pkg::bus_data_t store_data;
	fprint_pkg::task_key_t store_key;
	logic pause;
	logic fprint_enable;
	logic stall;
	bus_pkg::bus_addr_t master_address;
	logic master_write;
	bus_pkg::bus_data_t master_writedata;
	logic master_waitrequest;
	logic wr_done;

	bus_write_t exp_q [$];         // Writes the DUT still owes
	bus_write_t exp_head = '0;
	logic exp_any = 1'b0;
	fprint_pkg::crc_t model_crc;   // Reference CRC of the current block
	int errors = 0;
	int failed_tests = 0;
	int test_errors = 0;
	int word_count = 0;
	int expected_writes = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	fprint_store_unit #(
		.FIFO_DEPTH_LOG2(3)
	) fprint_store_unit_i (
		.clk(clk),
		.reset(reset),
		.store_valid(store_valid),
		.store_ready(store_ready),
		.store_address(store_address),
		.store_data(store_data),
		.store_key(store_key),
		.pause(pause),
		.fprint_enable(fprint_enable),
		.master_address(master_address),
		.master_write(master_write),
		.master_writedata(master_writedata),
		.master_waitrequest(master_waitrequest)
	);

	bus_responder bus_responder_i (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.master_address(master_address),
		.master_write(master_write),
		.master_writedata(master_writedata),
		.master_waitrequest(master_waitrequest)
	);

	assign wr_done = master_write & ~master_waitrequest;

	// Scoreboard head, moves on the edge a write completes
	always @(posedge clk) begin
		if (wr_done && exp_q.size() != 0)
			void'(exp_q.pop_front());
		exp_any = (exp_q.size() != 0);
		if (exp_any)
			exp_head = exp_q[0];
	end

	owed_check: assert property (@(posedge clk) disable iff (reset) wr_done |-> exp_any)
		else begin
			errors++;
			$display("Bus write to %h that no store accounts for", $sampled(master_address));
		end

	addr_check: assert property (@(posedge clk) disable iff (reset)
			wr_done && exp_any |-> master_address == exp_head.address)
		else begin
			errors++;
			$display("Mismatch master_address: got %h, expected %h",
				$sampled(master_address), $sampled(exp_head.address));
		end

	data_check: assert property (@(posedge clk) disable iff (reset)
			wr_done && exp_any |-> master_writedata == exp_head.data)
		else begin
			errors++;
			$display("Mismatch master_writedata: got %h, expected %h",
				$sampled(master_writedata), $sampled(exp_head.data));
		end

	// Reflected CRC-32 step per bit, word LSB first, no final inversion
	function automatic fprint_pkg::crc_t crc_next(input fprint_pkg::crc_t c,
			input bus_pkg::bus_data_t d);
		fprint_pkg::crc_t r;
		logic fb;
		r = c;
		for (int n = 0; n < 32; n++) begin
			fb = r[0] ^ d[n];
			r  = {1'b0, r[31:1]} ^ ({32{fb}} & fprint_pkg::CRC_POLY);
		end
		return r;
	endfunction

	// Scrambled word from a counter
	function automatic logic [31:0] mix(input int n);
		logic [31:0] x;
		x = n * 32'h9e3779b9;
		return x ^ (x >> 15) ^ 32'h5bd1e995;
	endfunction

	task automatic expect_write(input bus_pkg::bus_addr_t a, input bus_pkg::bus_data_t d);
		bus_write_t w;
		w.address = a;
		w.data    = d;
		exp_q.push_back(w);
		expected_writes++;
	endtask

	// Called on a falling edge, returns on the falling edge after acceptance
	task automatic send_store(input bus_pkg::bus_addr_t a, input bus_pkg::bus_data_t d,
			input fprint_pkg::task_key_t k);
		logic taken;
		taken         = 1'b0;
		store_valid   = 1'b1;
		store_address = a;
		store_data    = d;
		store_key     = k;
		while (!taken) begin
			taken = store_ready; // Settled since the last rising edge
			@(negedge clk);
		end
		store_valid = 1'b0;
	endtask

	task automatic ordinary_store(input fprint_pkg::task_key_t k);
		bus_pkg::bus_addr_t a;
		bus_pkg::bus_data_t d;
		logic [31:0] r;
		r = mix(word_count);
		d = mix(word_count + 7777);
		word_count++;
		a = r[26:0];
		if (a[5:0] == fprint_pkg::COMPARATOR_CRC_OFFSET)
			a[5:0] = ~a[5:0]; // Keep clear of the CRC slot
		model_crc = crc_next(model_crc, d);
		expect_write(a, d);
		send_store(a, d, k);
	endtask

	// Fingerprint store, issued tells whether its two beats reach the bus
	task automatic fprint_store(input fprint_pkg::task_key_t k, input logic issued);
		bus_pkg::bus_addr_t a;
		logic [31:0] r;
		r = mix(word_count);
		word_count++;
		a = {r[26:6], fprint_pkg::COMPARATOR_CRC_OFFSET};
		if (issued) begin
			expect_write(a, {model_crc[15:0], fprint_pkg::FPRINT_TAG_LOW, k});
			expect_write(a, {model_crc[31:16], fprint_pkg::FPRINT_TAG_HIGH, k});
		end
		model_crc = fprint_pkg::CRC_INIT; // Block ends even when dropped
		send_store(a, r, k);                // Data gets replaced by the CRC
	endtask

	// All owed writes out, then a quiet stretch to catch stray ones
	task automatic drain();
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (12) @(negedge clk);
	endtask

	task automatic finish_test(input string name);
		if (errors == test_errors) begin
			$display("PASS  %s", name);
		end else begin
			$display("FAIL  %s, %0d failed checks", name, errors - test_errors);
			failed_tests++;
		end
		test_errors = errors;
	endtask

	// Ends a run that stops making progress
	initial begin
		#(NUM_STORES * 200 * CLK_PERIOD);
		$display("Timeout, run exceeded %0d cycles", NUM_STORES * 200);
		$display("Test failures found");
		$finish;
	end

	initial begin
		reset         = 1'b1;
		store_valid   = 1'b0;
		store_address = '0;
		store_data    = '0;
		store_key     = '0;
		pause         = 1'b0;
		fprint_enable = 1'b1;
		stall         = 1'b0;
		model_crc     = fprint_pkg::CRC_INIT;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		repeat (12) ordinary_store(4'h3);
		drain();
		finish_test("ordinary stores in order under wait requests");

		repeat (4) ordinary_store(4'h6);
		fprint_store(4'h6, 1'b1);
		ordinary_store(4'h6); // Makes the fingerprint legal
		drain();
		finish_test("fingerprint released by a later store");

		repeat (2) ordinary_store(4'h5);
		fprint_store(4'h5, 1'b0);
		repeat (3) @(negedge clk);
		pause = 1'b1;         // One-cycle pulse
		@(negedge clk);
		pause = 1'b0;
		drain();
		repeat (2) ordinary_store(4'h5); // Fresh block from CRC_INIT
		fprint_store(4'h5, 1'b1);
		ordinary_store(4'h5);
		drain();
		finish_test("fingerprint dropped on pause");

		fprint_enable = 1'b0;
		repeat (3) ordinary_store(4'ha);
		fprint_store(4'ha, 1'b1);
		drain();
		fprint_enable = 1'b1;
		finish_test("fingerprint issued with fingerprinting disabled");

		stall = 1'b1;
		fork
			repeat (16) ordinary_store(4'h9);
			begin
				repeat (30) @(negedge clk);
				stall_check: assert (!store_ready)
					else begin
						errors++;
						$display("store_ready still high with the bus held in wait");
					end
				stall = 1'b0;
			end
		join
		drain();
		count_check: assert (bus_responder_i.addr_log.size() == expected_writes)
			else begin
				errors++;
				$display("Bus saw %0d writes where %0d were expected",
					bus_responder_i.addr_log.size(), expected_writes);
			end
		finish_test("burst stalled by wait request");

		$display("Tests run: 5, failed: %0d, failed checks: %0d", failed_tests, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
